// File: files.f
+incdir+verif
source/ahbMatrixPkg.sv
source/slotDecoder.sv
source/addrHoldStage.sv
source/defaultSlave.sv
source/dataPhaseMux.sv
source/ahbMasterStage.sv
verif/tbMasterStage.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and decides pass or fail from sim.log
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tbMasterStage \
  -f files.f -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0

// File: verif/tbStimulus.svh
// Transfer tasks for tbMasterStage; drive only on falling edges and leave the bus idle on return
`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

task automatic driveBus(input logic [31:0] addr, input htrans_t trans);
  masterAddr = '{haddr: addr, hwrite: 1'b0, hsize: 3'b010, htrans: trans};
  hwdata = $urandom;
endtask

// Samples hready at each rising edge until the data phase ends
task automatic waitDataDone();
  int cycles;
  cycles = 0;
  @(posedge clk);
  while (!hready && cycles < 40)
  begin
    cycles++;
    @(posedge clk);
  end
  if (!hready)
  begin
    $display("timeout: data phase did not complete within 40 cycles");
    timedOut = 1'b1;
  end
endtask

task automatic issueRead(input int slot, input logic [27:0] lowBits, input int gntDelay,
                         input int waitStates);
  logic [31:0] addr;
  addr = {slot[3:0], lowBits};
  @(negedge clk);
  waitCfg = waitStates;
  slotGnt = '1;
  if (gntDelay > 0)
    slotGnt[slot] = 1'b0;
  expAddr = addr;
  expReq = '0;
  expReq[slot] = 1'b1;
  driveBus(addr, transNonseq);
  if (gntDelay > 0)
  begin
    @(negedge clk);
    // Address was captured into the hold register on the last edge
    inWait = (gntDelay > 1);
    for (int k = 1; k < gntDelay; k++)
      @(negedge clk);
    inWait = 1'b0;
    slotGnt[slot] = 1'b1;
  end
  @(negedge clk);
  driveBus(32'h0, transIdle);
  expData = addr;
  expWait = waitStates;
  lowCnt = 0;
  checkRead = 1'b1;
  waitDataDone();
  @(negedge clk);
  checkRead = 1'b0;
endtask

task automatic provokeError(input logic [31:0] addr);
  @(negedge clk);
  driveBus(addr, transNonseq);
  @(negedge clk);
  driveBus(32'h0, transIdle);
  errStart = 1'b1;
  @(negedge clk);
  errStart = 1'b0;
  @(negedge clk);
endtask

task automatic sendIdleUnmapped(input logic [31:0] addr);
  @(negedge clk);
  driveBus(addr, transIdle);
  idleCheck = 1'b1;
  @(negedge clk);
  @(negedge clk);
  idleCheck = 1'b0;
  driveBus(32'h0, transIdle);
endtask

`endif

// File: verif/tbMasterStage.sv
// Single-outstanding stimulus only; slave models treat slotReq and slotGnt at a rising edge as accept
`default_nettype none

module tbMasterStage
  import ahbMatrixPkg::*;
;

  logic clk;
  logic rst;
  addrPhase_t masterAddr;
  logic [DataWidth-1:0] hwdata;
  logic hready;
  logic hresp;
  logic [DataWidth-1:0] hrdata;
  addrPhase_t slaveAddr;
  logic [DataWidth-1:0] slaveWdata;
  slotVec_t slotReq;
  slotVec_t slotGnt;
  slaveResp_t slaveResp [NumSlots];

  // Slave model state with one entry per slot
  logic pending [NumSlots];
  int waitLeft [NumSlots];
  logic [31:0] latched [NumSlots];
  int waitCfg;

  logic checkRead;
  logic inWait;
  logic errStart;
  logic idleCheck;
  logic timedOut;
  logic [31:0] expData;
  logic [31:0] expAddr;
  slotVec_t expReq;
  int expWait;
  int lowCnt;
  int errors;
  int testsRun;

  ahbMasterStage u_dut (
    .clk        (clk),
    .rst        (rst),
    .masterAddr (masterAddr),
    .hwdata     (hwdata),
    .hready     (hready),
    .hresp      (hresp),
    .hrdata     (hrdata),
    .slaveAddr  (slaveAddr),
    .slaveWdata (slaveWdata),
    .slotReq    (slotReq),
    .slotGnt    (slotGnt),
    .slaveResp  (slaveResp)
  );

  `include "tbStimulus.svh"

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (checkRead && !hready)
      lowCnt <= lowCnt + 1;
    for (int i = 0; i < NumSlots; i++)
    begin
      if (rst)
        pending[i] <= 1'b0;
      else if (slotReq[i] && slotGnt[i])
      begin
        pending[i] <= 1'b1;
        latched[i] <= slaveAddr.haddr;
        waitLeft[i] <= waitCfg;
      end
      else if (pending[i])
      begin
        if (waitLeft[i] == 0)
          pending[i] <= 1'b0;
        else
          waitLeft[i] <= waitLeft[i] - 1;
      end
    end
  end

  // Read data carries the slot number on top of the address low bits
  always @(negedge clk)
  begin
    for (int i = 0; i < NumSlots; i++)
      slaveResp[i] = '{hrdata: pending[i] ? {4'(i), latched[i][27:0]} : '0,
                       hreadyout: !pending[i] || (waitLeft[i] == 0), hresp: 1'b0};
  end

  task automatic logError(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  assert property (@(posedge clk) $fell(rst) |-> (slotReq == '0 && hready && !hresp))
    else logError($sformatf("mismatch after reset: slotReq=%h hready=%h hresp=%h",
      $sampled(slotReq), $sampled(hready), $sampled(hresp)));
  assert property (@(posedge clk) disable iff (rst) (checkRead && hready) |-> hrdata == expData)
    else logError($sformatf("mismatch hrdata: expected %h got %h",
      expData, $sampled(hrdata)));
  assert property (@(posedge clk) disable iff (rst) (checkRead && hready) |-> !hresp)
    else logError($sformatf("mismatch hresp: expected 0 got %h", $sampled(hresp)));
  assert property (@(posedge clk) disable iff (rst) (checkRead && hready) |-> lowCnt == expWait)
    else logError($sformatf("mismatch hready low cycles: expected %h got %h",
      expWait, $sampled(lowCnt)));
  assert property (@(posedge clk) disable iff (rst)
      inWait |-> (!hready && slotReq == expReq && slaveAddr.haddr == expAddr))
    else logError($sformatf("mismatch in hold: hready=%h slotReq=%h/%h haddr=%h/%h",
      $sampled(hready), $sampled(slotReq), expReq, $sampled(slaveAddr.haddr), expAddr));
  assert property (@(posedge clk) disable iff (rst)
      errStart |-> (!hready && hresp) ##1 (hready && hresp))
    else logError($sformatf("mismatch error response: hready=%h hresp=%h",
      $sampled(hready), $sampled(hresp)));
  assert property (@(posedge clk) disable iff (rst) idleCheck |-> (hready && !hresp))
    else logError($sformatf("mismatch idle response: hready=%h hresp=%h",
      $sampled(hready), $sampled(hresp)));
  assert property (@(posedge clk) slaveWdata == hwdata)
    else logError($sformatf("mismatch slaveWdata: expected %h got %h",
      $sampled(hwdata), $sampled(slaveWdata)));

  task automatic reportTest(input string name);
    testsRun++;
    $display("test %0d %s finished, errors so far %0d", testsRun, name, errors);
  endtask

  initial
  begin
    void'($urandom(41802));
    rst = 1'b1;
    masterAddr = '{haddr: '0, hwrite: 1'b0, hsize: 3'b010, htrans: transIdle};
    hwdata = '0;
    slotGnt = '1;
    for (int i = 0; i < NumSlots; i++)
      slaveResp[i] = '{hrdata: '0, hreadyout: 1'b1, hresp: 1'b0};
    waitCfg = 0;
    checkRead = 1'b0;
    inWait = 1'b0;
    errStart = 1'b0;
    idleCheck = 1'b0;
    timedOut = 1'b0;
    expData = '0;
    expAddr = '0;
    expReq = '0;
    expWait = 0;
    lowCnt = 0;
    errors = 0;
    testsRun = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    reportTest("reset state");
    issueRead(0, 28'h0000120, 0, 0);
    issueRead(1, 28'h00abcd4, 0, 0);
    issueRead(3, 28'h7654320, 0, 0);
    reportTest("enabled slot reads");
    if (!timedOut)
      issueRead(1, 28'h0003300, 2 + $urandom % 3, 0);
    if (!timedOut)
      issueRead(3, 28'h0004400, 2 + $urandom % 3, $urandom % 3);
    reportTest("grant wait");
    provokeError(32'h2000_0010);
    provokeError(32'h5000_0020);
    reportTest("default slave error");
    for (int n = 0; n < 4 && !timedOut; n++)
      issueRead(n == 2 ? 0 : n, 28'h0000040 + 28'(n), 0, 1 + $urandom % 4);
    reportTest("slave wait states");
    sendIdleUnmapped(32'h5000_0000);
    reportTest("idle to unmapped");
    $display("tests run %0d, errors %0d, timeout %0d", testsRun, errors, timedOut);
    if (errors == 0 && !timedOut)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/ahbMasterStage.sv
// One master, four slots; no lock support, write data goes to every slave stage unrouted
`default_nettype none

module ahbMasterStage
  import ahbMatrixPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  addrPhase_t           masterAddr,
  input  logic [DataWidth-1:0] hwdata,
  output logic                 hready,
  output logic                 hresp,
  output logic [DataWidth-1:0] hrdata,
  output addrPhase_t           slaveAddr,
  output logic [DataWidth-1:0] slaveWdata,
  output slotVec_t             slotReq,
  input  slotVec_t             slotGnt,
  input  slaveResp_t           slaveResp [NumSlots]
);

  logic accept;
  logic unmapped;
  logic waiting;
  logic dataReady;

  addrHoldStage u_addrHoldStage (
    .clk        (clk),
    .rst        (rst),
    .masterAddr (masterAddr),
    .dataReady  (dataReady),
    .slotGnt    (slotGnt),
    .slaveAddr  (slaveAddr),
    .slotReq    (slotReq),
    .unmapped   (unmapped),
    .accept     (accept),
    .waiting    (waiting)
  );

  // slotReq doubles as the decoded select for the data phase
  dataPhaseMux u_dataPhaseMux (
    .clk       (clk),
    .rst       (rst),
    .accept    (accept),
    .slotSel   (slotReq),
    .unmapped  (unmapped),
    .waiting   (waiting),
    .slaveResp (slaveResp),
    .hrdata    (hrdata),
    .hready    (hready),
    .hresp     (hresp),
    .dataReady (dataReady)
  );

  assign slaveWdata = hwdata;

endmodule

`default_nettype wire

// File: source/dataPhaseMux.sv
// Tracks a single outstanding data phase; with none pending the master sees OKAY and ready
`default_nettype none

module dataPhaseMux
  import ahbMatrixPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 accept,
  input  slotVec_t             slotSel,
  input  logic                 unmapped,
  input  logic                 waiting,
  input  slaveResp_t           slaveResp [NumSlots],
  output logic [DataWidth-1:0] hrdata,
  output logic                 hready,
  output logic                 hresp,
  output logic                 dataReady
);

  // Top bit selects the default slave
  logic [NumSlots:0] target;
  slaveResp_t        dsResp;
  slaveResp_t        selResp;

  defaultSlave u_defaultSlave (
    .clk   (clk),
    .rst   (rst),
    .start (accept && unmapped),
    .resp  (dsResp)
  );

  always_ff @(posedge clk)
  begin
    if (rst)
      target <= '0;
    else if (accept)
      target <= {unmapped, slotSel};
    else if (dataReady)
      target <= '0;
  end

  always_comb
  begin
    selResp = '{hrdata: '0, hreadyout: 1'b1, hresp: 1'b0};
    if (target[NumSlots])
      selResp = dsResp;
    for (int i = 0; i < NumSlots; i++)
    begin
      if (target[i])
        selResp = slaveResp[i];
    end
  end

  assign hrdata = selResp.hrdata;
  assign hresp = selResp.hresp;
  assign dataReady = selResp.hreadyout;

  // Master also stalls while an address sits in the hold register
  assign hready = dataReady && !waiting;

  property pTargetOneHot;
    @(posedge clk) disable iff (rst)
      accept |=> $onehot(target);
  endproperty

  assert property (pTargetOneHot)
    else $error("data-phase target not one-hot after accept: %h", target);

endmodule

`default_nettype wire

// File: source/defaultSlave.sv
// Two-cycle ERROR for every started transfer; read data is always zero
`default_nettype none

module defaultSlave
  import ahbMatrixPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  output slaveResp_t resp
);

  dsState_t state;
  dsState_t stateNext;

  always_comb
  begin
    case (state)
      dsIdle:      stateNext = start ? dsErrFirst : dsIdle;
      dsErrFirst:  stateNext = dsErrSecond;
      // Back-to-back unmapped transfers restart the error sequence
      dsErrSecond: stateNext = start ? dsErrFirst : dsIdle;
      default:     stateNext = dsIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= dsIdle;
    else
      state <= stateNext;
  end

  assign resp.hrdata = '0;
  assign resp.hreadyout = (state != dsErrFirst);
  assign resp.hresp = (state != dsIdle);

  // Hold stage cannot accept while the first error cycle stalls the bus
  property pNoStartInFirst;
    @(posedge clk) disable iff (rst)
      start |-> (state != dsErrFirst);
  endproperty

  assert property (pNoStartInFirst)
    else $error("default slave started during first error cycle");

endmodule

`default_nettype wire

// File: source/addrHoldStage.sv
// Holds one address phase until its slot grants; hwdata is not held, the master keeps it stable
`default_nettype none

module addrHoldStage
  import ahbMatrixPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  addrPhase_t masterAddr,
  input  logic       dataReady,
  input  slotVec_t   slotGnt,
  output addrPhase_t slaveAddr,
  output slotVec_t   slotReq,
  output logic       unmapped,
  output logic       accept,
  output logic       waiting
);

  holdState_t state;
  holdState_t stateNext;
  addrPhase_t holdReg;
  addrPhase_t presented;
  slotVec_t   slotSel;
  logic       decUnmapped;
  logic       active;
  logic       granted;
  logic       capture;

  // Held copy replaces the live bus while waiting for a grant
  assign presented = (state == holdWait) ? holdReg : masterAddr;

  slotDecoder u_slotDecoder (
    .addr     (presented),
    .slotSel  (slotSel),
    .unmapped (decUnmapped)
  );

  assign active = (presented.htrans == transNonseq) || (presented.htrans == transSeq);
  assign granted = |(slotSel & slotGnt);

  assign accept = active && dataReady && (granted || decUnmapped);
  assign capture = (state == holdIdle) && active && dataReady && !granted && !decUnmapped;

  assign slotReq = active ? slotSel : '0;
  assign unmapped = active && decUnmapped;
  assign slaveAddr = presented;
  assign waiting = (state == holdWait);

  always_comb
  begin
    case (state)
      holdIdle: stateNext = capture ? holdWait : holdIdle;
      holdWait: stateNext = accept ? holdIdle : holdWait;
      default:  stateNext = holdIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= holdIdle;
    else
      state <= stateNext;
  end

  always_ff @(posedge clk)
  begin
    if (capture)
      holdReg <= masterAddr;
  end

  // The slave stages must see the same address for the whole wait
  property pHoldStable;
    @(posedge clk) disable iff (rst)
      (waiting && !accept) |=> (slaveAddr == $past(slaveAddr));
  endproperty

  assert property (pHoldStable)
    else $error("slaveAddr changed while waiting for grant");

endmodule

`default_nettype wire

// File: source/slotDecoder.sv
// Purely combinational; disabled slots in SlotEnable decode as unmapped, not as a select
`default_nettype none

module slotDecoder
  import ahbMatrixPkg::*;
(
  input  addrPhase_t addr,
  output slotVec_t   slotSel,
  output logic       unmapped
);

  logic [SlotIdxWidth-1:0] slotIdx;

  assign slotIdx = addr.haddr[SlotMsb:SlotLsb];

  always_comb
  begin
    slotSel = '0;
    unmapped = 1'b1;
    for (int i = 0; i < NumSlots; i++)
    begin
      // Only enabled slots may claim the transfer
      if ((slotIdx == SlotIdxWidth'(i)) && SlotEnable[i])
      begin
        slotSel[i] = 1'b1;
        unmapped = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/ahbMatrixPkg.sv
// Four fixed slots on haddr[31:28]; slot 2 is disabled and indices 4 to 15 are unmapped
`default_nettype none

package ahbMatrixPkg;

  localparam int NumSlots = 4;
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;

  // Slot 2 has no slave behind it
  localparam logic [NumSlots-1:0] SlotEnable = 4'b1011;

  // Slot index field of haddr
  localparam int SlotMsb = 31;
  localparam int SlotLsb = 28;
  localparam int SlotIdxWidth = SlotMsb - SlotLsb + 1;

  typedef logic [NumSlots-1:0] slotVec_t;

  typedef enum logic [1:0] {
    transIdle   = 2'b00,
    transBusy   = 2'b01,
    transNonseq = 2'b10,
    transSeq    = 2'b11
  } htrans_t;

  typedef struct packed {
    logic [AddrWidth-1:0] haddr;
    logic                 hwrite;
    logic [2:0]           hsize;
    htrans_t              htrans;
  } addrPhase_t;

  typedef struct packed {
    logic [DataWidth-1:0] hrdata;
    logic                 hreadyout;
    logic                 hresp;
  } slaveResp_t;

  typedef enum logic {holdIdle, holdWait} holdState_t;

  typedef enum logic [1:0] {dsIdle, dsErrFirst, dsErrSecond} dsState_t;

endpackage

`default_nettype wire
